// File: files.f
verilog/spi_pkg.sv
verilog/spi_clk_div.sv
verilog/spi_tx_shift.sv
verilog/spi_rx_shift.sv
verilog/spi_sequencer.sv
verilog/spi_master.sv
tests/spi_slave_model.sv
tests/tb_spi_master.sv

// File: Makefile
# Verilator flow for the SPI master and its testbench

TOP = tb_spi_master

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f \
		--Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: tests/tb_spi_master.sv
// testbench for the mode 3 SPI master
// runs a table of transfers against a behavioral slave and checks the
// returned bytes, spi_clk pacing, slave select framing and the done pulse
`timescale 1ns/1ps

module tb_spi_master
    import spi_pkg::*;
();

    localparam int NROWS = 12;

    logic              sck = 1'b0;
    logic              clr;
    logic              start;
    logic [DATA_W-1:0] tdat;
    logic              mlb;
    logic [CDIV_W-1:0] cdiv;
    logic              miso;
    logic              ss;
    logic              spi_clk;
    logic              mosi;
    logic              done;
    logic [DATA_W-1:0] rdata;

    logic              slv_msb;     // slave bit order
    logic [DATA_W-1:0] slv_tx;      // slave reply byte
    logic [DATA_W-1:0] slv_rx;
    int                slv_rises;

    // stimulus table, one row per test
    string             t_name    [NROWS];
    logic [DATA_W-1:0] t_tdat    [NROWS];
    logic [DATA_W-1:0] t_sbyte   [NROWS];
    logic              t_mlb     [NROWS];
    logic [CDIV_W-1:0] t_cdiv    [NROWS];
    logic              t_restart [NROWS];   // pulse start again mid transfer

    integer seed;
    int     cyc       = 0;     // sck edges since time zero
    int     last_chg  = 0;     // edge of the last spi_clk change
    int     chg_cnt   = 0;
    int     bad_gap   = 0;     // wrong half-period seen, 0 when none
    int     cur_h     = 0;
    int     done_cnt  = 0;
    logic   clk_last  = 1'b1;
    int     test_errs = 0;
    int     pass_cnt  = 0;
    int     fail_cnt  = 0;
    logic   hung      = 1'b0;

    spi_master dut0 (
        .sck     (sck),
        .clr     (clr),
        .start   (start),
        .tdat    (tdat),
        .mlb     (mlb),
        .cdiv    (cdiv),
        .miso    (miso),
        .ss      (ss),
        .spi_clk (spi_clk),
        .mosi    (mosi),
        .done    (done),
        .rdata   (rdata)
    );

    spi_slave_model u_slave (
        .ss        (ss),
        .spi_clk   (spi_clk),
        .mosi      (mosi),
        .msb_first (slv_msb),
        .tx_byte   (slv_tx),
        .miso      (miso),
        .rx_byte   (slv_rx),
        .rise_cnt  (slv_rises)
    );

    always #2 sck = ~sck;   // 4 ns period

    ////////////////////////////////////////////////////////////////////////
    // monitors, sampled on the sck edge
    ////////////////////////////////////////////////////////////////////////

    always @(posedge sck) begin
        cyc = cyc + 1;
        if (spi_clk !== clk_last) begin
            if (chg_cnt > 0 && cyc - last_chg != cur_h) begin
                bad_gap = cyc - last_chg;
            end
            chg_cnt  = chg_cnt + 1;
            last_chg = cyc;
            clk_last = spi_clk;
        end
        if (done === 1'b1) begin
            done_cnt = done_cnt + 1;   // cycles with done high
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge sck);
        #1;                          // drive and sample just after the edge
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input int exp, input int act);
        $display("error %s: %s expected %0h actual %0h", name, what, exp, act);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("pass %s", name);
            pass_cnt++;
        end else begin
            $display("fail %s, %0d checks wrong", name, test_errs);
            fail_cnt++;
        end
        test_errs = 0;
    endtask

    task automatic set_row(input int i, input string name, input logic [7:0] td,
                           input logic [7:0] sb, input logic m, input logic [1:0] cd,
                           input logic rs);
        t_name[i]    = name;
        t_tdat[i]    = td;
        t_sbyte[i]   = sb;
        t_mlb[i]     = m;
        t_cdiv[i]    = cd;
        t_restart[i] = rs;
    endtask

    task automatic fill_table();
        logic [31:0] r;
        set_row(0, "div4_lsb",   8'hA5, 8'h3C, 1'b0, 2'd0, 1'b0);
        set_row(1, "div4_msb",   8'h96, 8'hC3, 1'b1, 2'd0, 1'b0);
        set_row(2, "div8_lsb",   8'h01, 8'h80, 1'b0, 2'd1, 1'b0);
        set_row(3, "div8_msb",   8'h80, 8'h01, 1'b1, 2'd1, 1'b0);
        set_row(4, "div16_lsb",  8'h5A, 8'hF0, 1'b0, 2'd2, 1'b0);
        set_row(5, "div16_msb",  8'h0F, 8'h6E, 1'b1, 2'd2, 1'b0);
        set_row(6, "div32_lsb",  8'h00, 8'hFF, 1'b0, 2'd3, 1'b0);
        set_row(7, "div32_msb",  8'hFF, 8'h00, 1'b1, 2'd3, 1'b0);
        r = $random(seed);
        set_row(8, "rand_a",     r[7:0], r[15:8], 1'b0, 2'd0, 1'b0);
        r = $random(seed);
        set_row(9, "rand_b",     r[7:0], r[15:8], 1'b1, 2'd1, 1'b0);
        r = $random(seed);
        set_row(10, "rand_c",    r[7:0], r[15:8], r[16], 2'd3, 1'b0);
        set_row(11, "restart",   8'h3D, 8'hB2, 1'b1, 2'd1, 1'b1);
    endtask

    task automatic check_reset_state();
        next_cycle();
        if (ss !== 1'b1) report_mismatch("after_reset", "ss", 1, int'(ss));
        if (spi_clk !== 1'b1) report_mismatch("after_reset", "spi_clk", 1, int'(spi_clk));
        if (mosi !== 1'b1) report_mismatch("after_reset", "mosi", 1, int'(mosi));
        if (done !== 1'b0) report_mismatch("after_reset", "done", 0, int'(done));
        if (rdata !== {DATA_W{1'b1}}) begin
            report_mismatch("after_reset", "rdata", 'hff, int'(rdata));
        end
        finish_test("after_reset");
    endtask

    ////////////////////////////////////////////////////////////////////////
    // one table row: start, wait for done, check
    ////////////////////////////////////////////////////////////////////////

    task automatic run_row(input int i);
        int h;
        int limit;
        int n;
        h        = 2 << t_cdiv[i];          // half-period doubles per code step
        limit    = 20 * int'(half_cycles(t_cdiv[i])) + 10;
        slv_msb  = t_mlb[i];
        slv_tx   = t_sbyte[i];
        cur_h    = h;
        chg_cnt  = 0;
        bad_gap  = 0;
        done_cnt = 0;
        start    = 1'b1;
        tdat     = t_tdat[i];
        mlb      = t_mlb[i];
        cdiv     = t_cdiv[i];
        next_cycle();                       // acceptance edge
        start = 1'b0;
        tdat  = ~t_tdat[i];                 // must not reach the transfer
        mlb   = ~t_mlb[i];
        cdiv  = t_cdiv[i] + 2'd1;
        n = 0;
        while (done !== 1'b1 && n < limit) begin
            start = t_restart[i] && (n == 4 * h);   // stray start mid transfer
            next_cycle();
            n = n + 1;
        end
        start = 1'b0;
        if (done !== 1'b1) begin
            $display("timeout in %s: done never came within %0d cycles of start",
                     t_name[i], limit);
            hung = 1'b1;
            test_errs++;
        end else begin
            if (rdata !== t_sbyte[i]) begin
                report_mismatch(t_name[i], "rdata", int'(t_sbyte[i]), int'(rdata));
            end
            if (slv_rx !== t_tdat[i]) begin
                report_mismatch(t_name[i], "slave byte", int'(t_tdat[i]), int'(slv_rx));
            end
            if (slv_rises != BITS_PER_XFER) begin
                report_mismatch(t_name[i], "rising edges", BITS_PER_XFER, slv_rises);
            end
            if (bad_gap != 0) report_mismatch(t_name[i], "half-period", h, bad_gap);
            if (chg_cnt != 2 * BITS_PER_XFER) begin
                report_mismatch(t_name[i], "spi_clk changes", 2 * BITS_PER_XFER, chg_cnt);
            end
            next_cycle();
            if (done !== 1'b0) report_mismatch(t_name[i], "done width", 0, int'(done));
            for (int k = 0; k < 3; k++) begin
                if (ss !== 1'b1) report_mismatch(t_name[i], "idle ss", 1, int'(ss));
                if (spi_clk !== 1'b1) begin
                    report_mismatch(t_name[i], "idle spi_clk", 1, int'(spi_clk));
                end
                next_cycle();
            end
            if (done_cnt != 1) report_mismatch(t_name[i], "done cycles", 1, done_cnt);
        end
        finish_test(t_name[i]);
    endtask

    initial begin
        seed    = 32'h9f1bb633;
        clr     = 1'b1;
        start   = 1'b0;
        tdat    = '0;
        mlb     = 1'b0;
        cdiv    = '0;
        slv_msb = 1'b0;
        slv_tx  = '1;
        fill_table();
        repeat (5) @(posedge sck);
        #1;
        clr = 1'b0;
        check_reset_state();
        for (int i = 0; i < NROWS && !hung; i++) begin
            run_row(i);
        end
        $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
                 fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/spi_slave_model.sv
// behavioral SPI mode 3 slave
// returns a preset byte on miso and collects mosi into a byte, both in
// the bit order given by the testbench, counting rising clock edges
// for each time it is selected
`timescale 1ns/1ps

module spi_slave_model
    import spi_pkg::*;
(
    input  logic              ss,
    input  logic              spi_clk,
    input  logic              mosi,
    input  logic              msb_first,
    input  logic [DATA_W-1:0] tx_byte,    // byte handed back to the master
    output logic              miso,
    output logic [DATA_W-1:0] rx_byte,    // byte seen from the master
    output int                rise_cnt
);

    logic              miso_q    = 1'b1;  // idle high while deselected
    logic              tx_active = 1'b0;
    logic              skip_fall = 1'b0;  // first falling edge keeps bit 0
    int                tx_idx    = 0;
    logic              rx_armed  = 1'b0;
    logic [DATA_W-1:0] rx_q      = '1;
    int                rise_q    = 0;

    assign miso     = miso_q;
    assign rx_byte  = rx_q;
    assign rise_cnt = rise_q;

    // bit idx of the byte in transfer order
    function automatic logic pick_bit(
        input logic [DATA_W-1:0] b,
        input int                idx,
        input logic              msb
    );
        if (msb) begin
            return b[DATA_W-1-idx];
        end
        return b[idx];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // transmit side, changes on falling spi_clk
    //////////////////////////////////////////////////////////////////////

    always @(ss or negedge spi_clk) begin
        if (ss !== 1'b0) begin
            tx_active = 1'b0;
            miso_q    = 1'b1;                 // released
        end else if (!tx_active) begin
            tx_active = 1'b1;                 // select just fell
            skip_fall = 1'b1;
            tx_idx    = 0;
            miso_q    = pick_bit(tx_byte, 0, msb_first);
        end else if (skip_fall) begin
            skip_fall = 1'b0;
        end else if (tx_idx < BITS_PER_XFER - 1) begin
            tx_idx = tx_idx + 1;
            miso_q = pick_bit(tx_byte, tx_idx, msb_first);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // receive side, samples on rising spi_clk
    //////////////////////////////////////////////////////////////////////

    always @(ss or posedge spi_clk) begin
        if (ss !== 1'b0) begin
            rx_armed = 1'b0;                  // keep last byte for the check
        end else if (!rx_armed) begin
            rx_armed = 1'b1;
            rise_q   = 0;
            rx_q     = '1;
        end else begin
            rise_q = rise_q + 1;
            if (msb_first) begin
                rx_q = {rx_q[DATA_W-2:0], mosi};
            end else begin
                rx_q = {mosi, rx_q[DATA_W-1:1]};
            end
        end
    end

endmodule

// File: verilog/spi_master.sv
// SPI master, mode 3, one byte per transfer
// the sequencer accepts a start and frames the transfer, the divider
// paces spi_clk, and the two shifters move mosi and miso side by side
`timescale 1ns/1ps

module spi_master
    import spi_pkg::*;
(
    input  logic              sck,
    input  logic              clr,
    input  logic              start,
    input  logic [DATA_W-1:0] tdat,
    input  logic              mlb,
    input  logic [CDIV_W-1:0] cdiv,
    input  logic              miso,
    output logic              ss,
    output logic              spi_clk,
    output logic              mosi,
    output logic              done,
    output logic [DATA_W-1:0] rdata
);

    logic              load;       // from sequencer, start accepted
    logic              run;        // from sequencer, transfer level
    logic              msb_first;  // bit order to both shifters
    logic              fall_stb;
    logic              rise_stb;
    logic [DATA_W-1:0] rx_byte;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    spi_sequencer u_seq (
        .sck       (sck),
        .clr       (clr),
        .start     (start),
        .mlb       (mlb),
        .rise_stb  (rise_stb),
        .rx_byte   (rx_byte),
        .load      (load),
        .run       (run),
        .msb_first (msb_first),
        .ss        (ss),
        .done      (done),
        .rdata     (rdata)
    );

    spi_clk_div u_div (
        .sck      (sck),
        .clr      (clr),
        .load     (load),
        .run      (run),
        .cdiv     (cdiv),
        .spi_clk  (spi_clk),
        .fall_stb (fall_stb),
        .rise_stb (rise_stb)
    );

    spi_tx_shift u_tx (
        .sck       (sck),
        .clr       (clr),
        .load      (load),
        .fall_stb  (fall_stb),
        .msb_first (msb_first),
        .tdat      (tdat),
        .mosi      (mosi)
    );

    spi_rx_shift u_rx (
        .sck       (sck),
        .clr       (clr),
        .load      (load),
        .rise_stb  (rise_stb),
        .msb_first (msb_first),
        .miso      (miso),
        .rx_byte   (rx_byte)
    );

endmodule

// File: verilog/spi_sequencer.sv
// SPI transfer sequencer
// accepts a start strobe while idle, holds slave select low for the
// transfer, counts rising SPI clock edges and, once the byte is in,
// pulses done with the received byte on rdata
// states are idle, transfer and finish
`timescale 1ns/1ps

module spi_sequencer
    import spi_pkg::*;
(
    input  logic              sck,
    input  logic              clr,
    input  logic              start,
    input  logic              mlb,        // 1 msb first, 0 lsb first
    input  logic              rise_stb,
    input  logic [DATA_W-1:0] rx_byte,
    output logic              load,       // acceptance cycle
    output logic              run,        // spi_clk allowed to run
    output logic              msb_first,
    output logic              ss,         // active low slave select
    output logic              done,
    output logic [DATA_W-1:0] rdata
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_XFER = 2'd1,
        ST_FIN  = 2'd2
    } state_t;

    typedef logic [$clog2(BITS_PER_XFER)-1:0] bcnt_t;

    localparam bcnt_t LAST_BIT = bcnt_t'(BITS_PER_XFER - 1);

    state_t state;
    bcnt_t  nbit;    // rising edges seen so far
    logic   mlb_q;   // bit order of the running transfer

    //////////////////////////////////////////////////////////////////////
    // handshake decode
    //////////////////////////////////////////////////////////////////////

    // starts are dropped during a transfer and in the done cycle
    assign load = start && (state == ST_IDLE) && !done;
    assign run  = (state == ST_XFER);

    // shifters load in the acceptance cycle, before mlb_q is valid
    assign msb_first = load ? mlb : mlb_q;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            state <= ST_IDLE;
            nbit  <= '0;
            mlb_q <= 1'b0;
            ss    <= 1'b1;
            done  <= 1'b0;
            rdata <= '1;
        end else begin
            done <= 1'b0;                        // single-cycle pulse
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        state <= ST_XFER;
                        nbit  <= '0;
                        mlb_q <= mlb;
                        ss    <= 1'b0;           // select the slave
                    end
                end
                ST_XFER: begin
                    if (rise_stb) begin
                        nbit <= nbit + 1'b1;
                        if (nbit == LAST_BIT) begin
                            state <= ST_FIN;     // last bit sampled this edge
                        end
                    end
                end
                ST_FIN: begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                    ss    <= 1'b1;
                    rdata <= rx_byte;            // holds until next done
                end
                default: begin
                    state <= ST_IDLE;
                    ss    <= 1'b1;
                end
            endcase
        end
    end

    a_done_pulse: assert property (@(posedge sck) disable iff (clr)
        done |=> !done);

    // the clock never runs with the slave deselected
    a_ss_run: assert property (@(posedge sck) disable iff (clr)
        run |-> !ss);

endmodule

// File: verilog/spi_rx_shift.sv
// SPI receive shifter
// collects miso into a byte at each rising strobe; with MSB first the
// new bit enters at the low end, with LSB first at the high end, so
// after eight strobes the byte sits in its natural order
`timescale 1ns/1ps

module spi_rx_shift
    import spi_pkg::*;
(
    input  logic              sck,
    input  logic              clr,
    input  logic              load,
    input  logic              rise_stb,
    input  logic              msb_first,
    input  logic              miso,
    output logic [DATA_W-1:0] rx_byte
);

    // byte register, preset on load so unsampled bits read as ones
    always_ff @(posedge sck) begin
        if (load) begin
            rx_byte <= '1;
        end else if (rise_stb) begin
            if (msb_first) begin
                rx_byte <= {rx_byte[DATA_W-2:0], miso};  // left shift
            end else begin
                rx_byte <= {miso, rx_byte[DATA_W-1:1]};  // right shift
            end
        end
    end

    // a rising strobe only comes after a load has set the register up
    a_load_first: assert property (@(posedge sck) disable iff (clr)
        rise_stb |-> !$isunknown(rx_byte));

endmodule

// File: verilog/spi_tx_shift.sv
// SPI transmit shifter
// takes the transmit byte on load and presents its first bit on mosi at
// once; the first falling strobe of a transfer keeps that bit, each later
// falling strobe moves on to the next one, MSB or LSB first
`timescale 1ns/1ps

module spi_tx_shift
    import spi_pkg::*;
(
    input  logic              sck,
    input  logic              clr,
    input  logic              load,
    input  logic              fall_stb,
    input  logic              msb_first,
    input  logic [DATA_W-1:0] tdat,
    output logic              mosi
);

    logic [DATA_W-1:0] treg;        // bits still to go, current bit at the edge
    logic              skip_first;  // first falling edge carries no shift

    // data register, refilled on every load
    always_ff @(posedge sck) begin
        if (load) begin
            treg <= tdat;
        end else if (fall_stb && !skip_first) begin
            if (msb_first) begin
                treg <= {treg[DATA_W-2:0], 1'b1};  // shift left, ones behind
            end else begin
                treg <= {1'b1, treg[DATA_W-1:1]};  // shift right
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mosi and first-edge flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            mosi       <= 1'b1;
            skip_first <= 1'b0;
        end else if (load) begin
            mosi       <= msb_first ? tdat[DATA_W-1] : tdat[0];
            skip_first <= 1'b1;
        end else if (fall_stb) begin
            if (skip_first) begin
                skip_first <= 1'b0;              // bit already on the line
            end else if (msb_first) begin
                mosi <= treg[DATA_W-2];          // next bit down
            end else begin
                mosi <= treg[1];                 // next bit up
            end
        end
    end

    // line is idle high straight out of reset
    a_mosi_rst: assert property (@(posedge sck) $fell(clr) |-> mosi);

endmodule

// File: verilog/spi_clk_div.sv
// SPI clock divider
// generates the mode 3 spi_clk from sck while run is high, idling high
// otherwise, and flags each falling and rising change with a one-cycle
// strobe that lines up with the sck edge where spi_clk changes
`timescale 1ns/1ps

module spi_clk_div
    import spi_pkg::*;
(
    input  logic              sck,
    input  logic              clr,
    input  logic              load,      // start accepted, latch divide code
    input  logic              run,       // transfer in progress
    input  logic [CDIV_W-1:0] cdiv,
    output logic              spi_clk,
    output logic              fall_stb,  // spi_clk goes low at this edge
    output logic              rise_stb   // spi_clk goes high at this edge
);

    logic [HALF_W-1:0] h;     // half-period in sck cycles
    logic [HALF_W-1:0] cnt;   // cycles into the current half-period
    logic              tick;  // last cycle of a half-period

    //////////////////////////////////////////////////////////////////////
    // ratio latch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            h <= '0;
        end else if (load) begin
            h <= half_cycles(cdiv);  // held for the whole transfer
        end
    end

    //////////////////////////////////////////////////////////////////////
    // half-period counter and clock toggle
    //////////////////////////////////////////////////////////////////////

    assign tick = run && (cnt == h - 1'b1);

    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            cnt     <= '0;
            spi_clk <= 1'b1;            // mode 3 idles high
        end else if (!run) begin
            cnt     <= '0;              // idle, park the clock high
            spi_clk <= 1'b1;
        end else if (tick) begin
            cnt     <= '0;
            spi_clk <= ~spi_clk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // the strobe is high in the cycle before the edge that flips spi_clk,
    // so a block acting on it updates together with spi_clk
    assign fall_stb = tick &  spi_clk;
    assign rise_stb = tick & ~spi_clk;

    // one direction per edge only
    a_stb_excl: assert property (@(posedge sck) disable iff (clr)
        !(fall_stb && rise_stb));

    // spi_clk only moves on a strobe, so run never drops with the clock low
    a_clk_on_stb: assert property (@(posedge sck) disable iff (clr)
        (spi_clk != $past(spi_clk)) |-> $past(fall_stb || rise_stb));

endmodule

// File: verilog/spi_pkg.sv
// SPI master shared definitions
// widths for the byte path and divide code, bits per transfer, and the
// mapping from divide code to SPI clock half-period in system cycles
package spi_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_W        = 8;   // one transfer byte
    localparam int CDIV_W        = 2;   // divide code, four ratios
    localparam int HALF_W        = 5;   // half-period count, holds up to 16
    localparam int BITS_PER_XFER = 8;   // rising edges that close a transfer

    //////////////////////////////////////////////////////////////////////
    // divide code to half-period
    //////////////////////////////////////////////////////////////////////

    // spi_clk period is twice the half-period, so code 0 is sck/4
    // and code 3 is sck/32
    function automatic logic [HALF_W-1:0] half_cycles(
        input logic [CDIV_W-1:0] code
    );
        logic [HALF_W-1:0] h;
        case (code)
            2'd0:    h = 5'd2;   // sck/4
            2'd1:    h = 5'd4;   // sck/8
            2'd2:    h = 5'd8;   // sck/16
            default: h = 5'd16;  // sck/32
        endcase
        return h;
    endfunction

endpackage
